// ==== hw/rv32iPkg.sv ====
package rv32iPkg;

    // ==============================
    // Widths
    // ==============================
    localparam int unsigned xlen     = 32;  // Data path width
    localparam int unsigned regAddrW = 5;   // Register index
    localparam int unsigned regDepth = 32;  // x0..x31
    localparam int unsigned funct3W  = 3;

    // ==============================
    // Opcodes
    // ==============================
    localparam logic [6:0] opOp     = 7'b0110011;  // R-type
    localparam logic [6:0] opOpImm  = 7'b0010011;  // I-type ALU
    localparam logic [6:0] opBranch = 7'b1100011;  // SB-type
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;

    // ALU funct3, shared by OP and OP-IMM
    localparam logic [funct3W-1:0] f3AddSub = 3'b000;
    localparam logic [funct3W-1:0] f3Sll    = 3'b001;
    localparam logic [funct3W-1:0] f3Slt    = 3'b010;
    localparam logic [funct3W-1:0] f3Sltu   = 3'b011;
    localparam logic [funct3W-1:0] f3Xor    = 3'b100;
    localparam logic [funct3W-1:0] f3SrlSra = 3'b101;
    localparam logic [funct3W-1:0] f3Or     = 3'b110;
    localparam logic [funct3W-1:0] f3And    = 3'b111;

    // Branch funct3
    // Bit 0 set means the inverted compare (NE, GE, GEU)
    localparam logic [funct3W-1:0] f3Beq  = 3'b000;
    localparam logic [funct3W-1:0] f3Bne  = 3'b001;
    localparam logic [funct3W-1:0] f3Blt  = 3'b100;
    localparam logic [funct3W-1:0] f3Bge  = 3'b101;
    localparam logic [funct3W-1:0] f3Bltu = 3'b110;
    localparam logic [funct3W-1:0] f3Bgeu = 3'b111;

    // ==============================
    // ALU operations
    // ==============================
    typedef enum logic [3:0] {
        aluAdd  = 4'd0,
        aluSub  = 4'd1,
        aluSll  = 4'd2,
        aluSlt  = 4'd3,   // Signed less than
        aluSltu = 4'd4,   // Unsigned less than
        aluXor  = 4'd5,
        aluSrl  = 4'd6,
        aluSra  = 4'd7,
        aluOr   = 4'd8,
        aluAnd  = 4'd9,
        aluSeq  = 4'd10   // Set if equal, branches only
    } aluOpT;

    // Control bundle, 10 bits
    typedef struct packed {
        logic  aluSrcImm;  // Operand B from immediate
        aluOpT aluOp;
        logic  branchEn;
        logic  memWrEn;
        logic  memRdEn;
        logic  regWrEn;
        logic  memToReg;   // Writeback from load data
    } ctrlT;

    // All controls low
    localparam ctrlT ctrlNop = '0;

endpackage

// ==== hw/idExIf.sv ====
`timescale 1ns/100ps

// Decoded instruction on its way into the execute register
interface idExIf;
    import rv32iPkg::*;

    ctrlT                ctrl;
    logic [xlen-1:0]     imm;      // Sign-extended I/S/SB immediate
    logic [xlen-1:0]     rs1Data;
    logic [xlen-1:0]     rs2Data;
    logic [regAddrW-1:0] rd;
    logic [funct3W-1:0]  funct3;   // Branch sense in execute
    logic [xlen-1:0]     pc;

    // Control decoder side
    modport decode (
        output ctrl,
        output imm
    );

    // Consumer, the decode/execute register
    modport stage (
        input ctrl,
        input imm,
        input rs1Data,
        input rs2Data,
        input rd,
        input funct3,
        input pc
    );

endinterface

// ==== hw/idControl.sv ====
`timescale 1ns/100ps

module idControl (
    input  logic [rv32iPkg::xlen-1:0] instr,
    input  logic                      bubble,  // Stall, squash or empty slot
    idExIf.decode                     dec
);
    import rv32iPkg::*;

    // ==============================
    // Fields and immediates
    // ==============================
    logic [6:0]         opcode;
    logic [funct3W-1:0] funct3;
    logic               funct7b5;  // SUB / SRA select
    logic [xlen-1:0]    immI;
    logic [xlen-1:0]    immS;
    logic [xlen-1:0]    immB;
    aluOpT              baseOp;    // OP / OP-IMM mapping
    ctrlT               ctrlRaw;   // Before bubble masking

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];

    assign immI = {{(xlen - 12){instr[31]}}, instr[31:20]};
    assign immS = {{(xlen - 12){instr[31]}}, instr[31:25], instr[11:7]};
    // Branch offset, LSB always zero
    assign immB = {{(xlen - 13){instr[31]}}, instr[31], instr[7],
                   instr[30:25], instr[11:8], 1'b0};

    // Shared ALU mapping for register and immediate forms
    always_comb begin
        case (funct3)
            // ADDI has no SUB form, bit 30 is immediate there
            f3AddSub: baseOp = (opcode == opOp && funct7b5) ? aluSub : aluAdd;
            f3Sll:    baseOp = aluSll;
            f3Slt:    baseOp = aluSlt;
            f3Sltu:   baseOp = aluSltu;
            f3Xor:    baseOp = aluXor;
            f3SrlSra: baseOp = funct7b5 ? aluSra : aluSrl;  // SRAI too
            f3Or:     baseOp = aluOr;
            f3And:    baseOp = aluAnd;
            default:  baseOp = aluAdd;
        endcase
    end

    // ==============================
    // Per-opcode controls
    // ==============================
    always_comb begin
        ctrlRaw = ctrlNop;  // Unknown opcode stays a NOP
        dec.imm = '0;

        case (opcode)
            opOp: begin
                ctrlRaw.aluOp   = baseOp;
                ctrlRaw.regWrEn = 1'b1;
            end

            opOpImm: begin
                dec.imm           = immI;
                ctrlRaw.aluSrcImm = 1'b1;
                ctrlRaw.aluOp     = baseOp;
                ctrlRaw.regWrEn   = 1'b1;
            end

            opLoad: begin
                dec.imm           = immI;  // Address offset
                ctrlRaw.aluSrcImm = 1'b1;
                ctrlRaw.aluOp     = aluAdd;
                ctrlRaw.memRdEn   = 1'b1;
                ctrlRaw.regWrEn   = 1'b1;
                ctrlRaw.memToReg  = 1'b1;
            end

            opStore: begin
                dec.imm           = immS;
                ctrlRaw.aluSrcImm = 1'b1;
                ctrlRaw.aluOp     = aluAdd;
                ctrlRaw.memWrEn   = 1'b1;
            end

            opBranch: begin
                dec.imm          = immB;
                ctrlRaw.branchEn = 1'b1;
                // Inverted forms share the compare, ALU flips on funct3[0]
                case (funct3)
                    f3Beq, f3Bne:   ctrlRaw.aluOp = aluSeq;
                    f3Blt, f3Bge:   ctrlRaw.aluOp = aluSlt;
                    f3Bltu, f3Bgeu: ctrlRaw.aluOp = aluSltu;
                    default:        ctrlRaw.branchEn = 1'b0;  // Reserved code
                endcase
            end

            default: begin
                ctrlRaw = ctrlNop;
            end
        endcase
    end

    // Bubble kills every enable, regWrEn included
    assign dec.ctrl = bubble ? ctrlNop : ctrlRaw;

endmodule

// ==== hw/regFile.sv ====
`timescale 1ns/100ps

module regFile (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic [rv32iPkg::regAddrW-1:0] rs1,
    input  logic [rv32iPkg::regAddrW-1:0] rs2,
    input  logic [rv32iPkg::regAddrW-1:0] rdAddr,
    input  logic                          wrEn,
    input  logic [rv32iPkg::xlen-1:0]     wrData,
    output logic [rv32iPkg::xlen-1:0]     rs1Data,
    output logic [rv32iPkg::xlen-1:0]     rs2Data
);
    import rv32iPkg::*;

    logic [xlen-1:0] regs [regDepth];

    // One read port, x0 first, then same-cycle write bypass
    function automatic logic [xlen-1:0] readPort(input logic [regAddrW-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (wrEn && addr == rdAddr) begin
            return wrData;  // Writeback stage forwarding
        end
        return regs[addr];
    endfunction

    // Clears on reset, x0 never written
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < regDepth; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && rdAddr != '0) begin
            regs[rdAddr] <= wrData;
        end
    end

    always_comb begin
        rs1Data = readPort(rs1);
        rs2Data = readPort(rs2);
    end

endmodule

// ==== hw/hazardUnit.sv ====
`timescale 1ns/100ps

module hazardUnit (
    input  logic                          instValid,
    input  logic [rv32iPkg::regAddrW-1:0] rs1,          // Zero if not read
    input  logic [rv32iPkg::regAddrW-1:0] rs2,          // Zero if not read
    input  logic [rv32iPkg::regAddrW-1:0] exRd,
    input  logic                          exRegWr,
    input  logic                          branchTaken,  // Squash decode
    output logic                          bubble,
    output logic                          instReady
);

    // ==============================
    // Execute-stage dependence
    // ==============================
    logic rs1Hit;
    logic rs2Hit;
    logic stall;

    // x0 never creates a dependence
    assign rs1Hit = (rs1 != '0) && (rs1 == exRd);
    assign rs2Hit = (rs2 != '0) && (rs2 == exRd);

    // Only ALU and load results in flight, writeback is bypassed in regFile
    assign stall = instValid && exRegWr && (rs1Hit || rs2Hit);

    // Next cycle execute holds the bubble, so stall drops after one cycle

    // Nothing real goes to execute on stall, squash or empty slot
    assign bubble = stall || branchTaken || !instValid;

    // Fetch holds the instruction while low
    assign instReady = !stall;

endmodule

// ==== hw/aluUnit.sv ====
`timescale 1ns/100ps

module aluUnit (
    input  rv32iPkg::aluOpT              aluOp,
    input  logic [rv32iPkg::xlen-1:0]    opA,
    input  logic [rv32iPkg::xlen-1:0]    opB,
    input  logic [rv32iPkg::funct3W-1:0] funct3,      // Bit 0 inverts the branch
    input  logic                         branchEn,
    input  logic [rv32iPkg::xlen-1:0]    pc,
    input  logic [rv32iPkg::xlen-1:0]    imm,
    output logic [rv32iPkg::xlen-1:0]    result,
    output logic                         branchTaken,
    output logic [rv32iPkg::xlen-1:0]    branchTarget
);
    import rv32iPkg::*;

    logic [$clog2(xlen)-1:0] shamt;  // Low five bits of opB
    logic                    ltSigned;
    logic                    ltUnsigned;

    assign shamt      = opB[$clog2(xlen)-1:0];
    assign ltSigned   = $signed(opA) < $signed(opB);
    assign ltUnsigned = opA < opB;

    // ==============================
    // Operations
    // ==============================
    always_comb begin
        case (aluOp)
            aluAdd:  result = opA + opB;
            aluSub:  result = opA - opB;
            aluSll:  result = opA << shamt;
            aluSlt:  result = {{(xlen - 1){1'b0}}, ltSigned};
            aluSltu: result = {{(xlen - 1){1'b0}}, ltUnsigned};
            aluXor:  result = opA ^ opB;
            aluSrl:  result = opA >> shamt;
            aluSra:  result = $signed(opA) >>> shamt;  // Arithmetic
            aluOr:   result = opA | opB;
            aluAnd:  result = opA & opB;
            aluSeq:  result = {{(xlen - 1){1'b0}}, opA == opB};
            default: result = '0;
        endcase
    end

    // Compare in bit 0, flipped for BNE/BGE/BGEU
    assign branchTaken  = branchEn && (result[0] ^ funct3[0]);
    assign branchTarget = pc + imm;  // SB offset already doubled

endmodule

// ==== hw/coreTop.sv ====
`timescale 1ns/100ps

module coreTop (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          instValid,
    input  logic [rv32iPkg::xlen-1:0]     instr,
    input  logic [rv32iPkg::xlen-1:0]     instPc,
    input  logic [rv32iPkg::xlen-1:0]     memRdData,     // One cycle after memRdEn
    output logic                          instReady,
    output logic                          branchTaken,   // Pulse in execute
    output logic [rv32iPkg::xlen-1:0]     branchTarget,
    output logic                          memRdEn,
    output logic                          memWrEn,
    output logic [rv32iPkg::xlen-1:0]     memAddr,
    output logic [rv32iPkg::xlen-1:0]     memWrData,
    output logic                          wbEn,
    output logic [rv32iPkg::regAddrW-1:0] wbAddr,
    output logic [rv32iPkg::xlen-1:0]     wbData
);
    import rv32iPkg::*;

    idExIf idEx ();

    logic                bubble;
    logic                usesRs1;
    logic                usesRs2;

    // Execute stage
    ctrlT                exCtrl;
    logic [xlen-1:0]     exImm;
    logic [xlen-1:0]     exRs1Data;
    logic [xlen-1:0]     exRs2Data;
    logic [regAddrW-1:0] exRd;
    logic [funct3W-1:0]  exFunct3;
    logic [xlen-1:0]     exPc;
    logic [xlen-1:0]     aluOpB;
    logic [xlen-1:0]     aluResult;

    // Writeback stage
    logic [xlen-1:0]     wbResult;
    logic [regAddrW-1:0] wbRd;
    logic                wbRegWr;
    logic                wbMemToReg;

    // ==============================
    // Decode, cycle 0
    // ==============================
    // Source usage, keeps immediate bits out of the hazard compare
    always_comb begin
        usesRs1 = 1'b0;
        usesRs2 = 1'b0;
        case (instr[6:0])
            opOp, opStore, opBranch: begin
                usesRs1 = 1'b1;
                usesRs2 = 1'b1;
            end
            opOpImm, opLoad: begin
                usesRs1 = 1'b1;
            end
            default: begin
                usesRs1 = 1'b0;  // Unknown opcode reads nothing
            end
        endcase
    end

    assign idEx.rd     = instr[11:7];
    assign idEx.funct3 = instr[14:12];
    assign idEx.pc     = instPc;

    idControl u_idControl (.instr(instr), .bubble(bubble), .dec(idEx.decode));

    regFile u_regFile (
        .clk    (clk),
        .rstN   (rstN),
        .rs1    (instr[19:15]),
        .rs2    (instr[24:20]),
        .rdAddr (wbRd),
        .wrEn   (wbEn),
        .wrData (wbData),          // Bypassed to decode same cycle
        .rs1Data(idEx.rs1Data),
        .rs2Data(idEx.rs2Data)
    );

    hazardUnit u_hazardUnit (
        .instValid  (instValid),
        .rs1        (usesRs1 ? instr[19:15] : '0),
        .rs2        (usesRs2 ? instr[24:20] : '0),
        .exRd       (exRd),
        .exRegWr    (exCtrl.regWrEn),
        .branchTaken(branchTaken),
        .bubble     (bubble),
        .instReady  (instReady)
    );

    // ==============================
    // Execute, cycle 1
    // ==============================
    always_ff @(posedge clk) begin
        if (!rstN) begin
            exCtrl <= ctrlNop;
        end else begin
            exCtrl <= idEx.ctrl;  // Already zero on bubble
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        exImm     <= idEx.imm;
        exRs1Data <= idEx.rs1Data;
        exRs2Data <= idEx.rs2Data;
        exRd      <= idEx.rd;
        exFunct3  <= idEx.funct3;
        exPc      <= idEx.pc;
    end

    assign aluOpB = exCtrl.aluSrcImm ? exImm : exRs2Data;

    aluUnit u_aluUnit (
        .aluOp       (exCtrl.aluOp),
        .opA         (exRs1Data),
        .opB         (aluOpB),
        .funct3      (exFunct3),
        .branchEn    (exCtrl.branchEn),
        .pc          (exPc),
        .imm         (exImm),
        .result      (aluResult),
        .branchTaken (branchTaken),
        .branchTarget(branchTarget)
    );

    assign memRdEn   = exCtrl.memRdEn;
    assign memWrEn   = exCtrl.memWrEn;
    assign memAddr   = aluResult;  // Base plus offset
    assign memWrData = exRs2Data;

    // ==============================
    // Writeback, cycle 2
    // ==============================
    always_ff @(posedge clk) begin
        if (!rstN) begin
            wbRegWr    <= 1'b0;
            wbMemToReg <= 1'b0;
        end else begin
            wbRegWr    <= exCtrl.regWrEn;
            wbMemToReg <= exCtrl.memToReg;
        end
    end

    always_ff @(posedge clk) begin
        wbResult <= aluResult;
        wbRd     <= exRd;
    end

    assign wbEn   = wbRegWr && (wbRd != '0);  // x0 writes dropped
    assign wbAddr = wbRd;
    assign wbData = wbMemToReg ? memRdData : wbResult;

endmodule

// ==== tests/tbClock.sv ====
`timescale 1ns/100ps

module tbClock (
    output logic clk,
    output logic rstN
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Low for three rising edges, released away from the edge
    initial begin
        rstN = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
    end

endmodule

// ==== tests/tbCore.sv ====
`timescale 1ns/100ps

module tbCore;
    import rv32iPkg::*;

    logic clk, rstN, instValid, instReady, branchTaken, memRdEn, memWrEn, wbEn;
    logic [xlen-1:0] instr, instPc, memRdData, branchTarget, memAddr, memWrData, wbData;
    logic [regAddrW-1:0] wbAddr;

    logic [xlen-1:0] dataMem [256];  // DUT side memory
    logic [xlen-1:0] refMem  [256];  // Reference copy
    logic [xlen-1:0] refRegs [regDepth];
    logic [regAddrW-1:0] expAddr[$];
    logic [xlen-1:0] expData[$], stAddr[$], stData[$];
    int expCycle[$];
    int seed = 42901;
    int errCount = 0, cycleCount = 0, issuedCount = 0, writesSeen = 0;
    logic [xlen-1:0] pcNow = 32'h100;

    tbClock u_clock (.clk(clk), .rstN(rstN));

    coreTop i_dut (.clk(clk), .rstN(rstN), .instValid(instValid), .instr(instr),
        .instPc(instPc), .memRdData(memRdData), .instReady(instReady),
        .branchTaken(branchTaken), .branchTarget(branchTarget), .memRdEn(memRdEn),
        .memWrEn(memWrEn), .memAddr(memAddr), .memWrData(memWrData), .wbEn(wbEn),
        .wbAddr(wbAddr), .wbData(wbData));

    // Data memory returning read data one cycle after memRdEn
    always @(posedge clk) begin
        if (memRdEn) memRdData <= dataMem[memAddr[9:2]];
        if (memWrEn) dataMem[memAddr[9:2]] <= memWrData;
    end

    // ==============================
    // Compare tasks
    // ==============================
    task automatic checkReg(input string name, input logic [xlen-1:0] exp, act);
        if (exp !== act) begin
            errCount++;
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic checkIdx(input string name, input logic [regAddrW-1:0] exp, act);
        if (exp !== act) begin
            errCount++;
            $display("[ERROR] %s expected x%0d actual x%0d", name, exp, act);
        end
    endtask

    task automatic checkBranch(input string name, input logic expTk,
                               input logic [xlen-1:0] expTgt, input logic actTk,
                               input logic [xlen-1:0] actTgt);
        if (expTk !== actTk || (expTk && expTgt !== actTgt)) begin
            errCount++;
            $display("[ERROR] %s expected %b/%h actual %b/%h", name, expTk, expTgt,
                     actTk, actTgt);
        end
    endtask

    // Cycles with instReady low while one instruction is held
    task automatic checkStalls(input string name, input int exp, act);
        if (exp != act) begin
            errCount++;
            $display("[ERROR] %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    // ==============================
    // Encoders and ISA model
    // ==============================
    function automatic logic [31:0] encR(input logic alt, input logic [4:0] rs2, rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, opOp};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2, rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] off, input logic [4:0] rs2, rs1,
                                         input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opBranch};
    endfunction

    function automatic logic [31:0] refOp(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic refCond(input logic [2:0] f3, input logic [31:0] a, b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    // Program-order model queueing expected writes and stores
    task automatic modelExec(input logic [31:0] ins, input int acc);
        logic [31:0] a, b, immI, immS, res;
        logic [4:0] rd;
        logic wr;
        a = refRegs[ins[19:15]];
        b = refRegs[ins[24:20]];
        immI = {{20{ins[31]}}, ins[31:20]};
        immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        rd = ins[11:7];
        wr = 1'b1;
        res = '0;
        case (ins[6:0])
            opOp: res = refOp(ins[14:12], ins[30], a, b);
            opOpImm: res = refOp(ins[14:12], ins[14:12] == 3'd5 && ins[30], a, immI);
            opLoad: res = refMem[(a + immI) >> 2 & 32'hFF];
            opStore: begin
                wr = 1'b0;
                stAddr.push_back(a + immS);
                stData.push_back(b);
                refMem[(a + immS) >> 2 & 32'hFF] = b;
            end
            default: wr = 1'b0;  // Branches and unknown opcodes
        endcase
        if (wr && rd != 0) begin
            refRegs[rd] = res;
            expAddr.push_back(rd);
            expData.push_back(res);
            expCycle.push_back(acc + 1);
        end
    endtask

    // Present one instruction and hold it through stalls
    task automatic issueInstr(input logic [31:0] ins, output int stalls);
        @(negedge clk);
        instValid = 1'b1;
        instr = ins;
        instPc = pcNow;
        stalls = 0;
        #1;
        while (!instReady) begin
            stalls++;
            @(negedge clk);
            #1;
        end
        issuedCount++;
        modelExec(ins, cycleCount + 1);
        pcNow += 4;
    endtask

    // Writeback and store monitor
    always @(negedge clk) begin
        if (rstN && wbEn) begin
            writesSeen++;
            if (expAddr.size() == 0) begin
                errCount++;
                $display("Register write to x%0d with no instruction expecting it", wbAddr);
            end else begin
                checkIdx("wbAddr", expAddr.pop_front(), wbAddr);
                checkReg("wbData", expData.pop_front(), wbData);
                if (expCycle.pop_front() != cycleCount) begin
                    errCount++;
                    $display("Register write to x%0d arrived at the wrong cycle", wbAddr);
                end
            end
        end
        if (rstN && memWrEn) begin
            if (stAddr.size() == 0) begin
                errCount++;
                $display("Store seen with no store instruction in flight");
            end else begin
                checkReg("memAddr", stAddr.pop_front(), memAddr);
                checkReg("memWrData", stData.pop_front(), memWrData);
            end
        end
    end

    // Timeout scaled by the instructions issued so far
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > 4 * issuedCount + 50) begin
            $display("Run stopped: cycle limit reached, the pipeline stopped responding");
            $display("Test FAILED");
            $finish;
        end
    end

    // ==============================
    // Directed tests
    // ==============================
    task automatic testReset();
        @(negedge clk);
        if (wbEn || memRdEn || memWrEn || branchTaken || !instReady) begin
            errCount++;
            $display("Outputs not idle after reset");
        end
    endtask

    task automatic testRType();
        logic [2:0] f3s [10] = '{0, 0, 1, 2, 3, 4, 5, 5, 6, 7};
        logic alts [10] = '{0, 1, 0, 0, 0, 0, 0, 1, 0, 0};
        int st;
        for (int k = 0; k < 10; k++) begin
            issueInstr(encI(12'(($random(seed) & 63) * 4), 0, 3'b010, 1, opLoad), st);
            issueInstr(encI(12'(($random(seed) & 63) * 4), 0, 3'b010, 2, opLoad), st);
            issueInstr(encR(alts[k], 2, 1, f3s[k], 3), st);
        end
    endtask

    task automatic testIType();
        int st;
        for (int f = 0; f < 8; f++) begin
            if (f == 1 || f == 5) begin
                issueInstr(encI({1'b0, f == 5 && seed[0], 5'b0, 5'($random(seed))},
                                3, 3'(f), 4, opOpImm), st);
                issueInstr(encI({7'b0100000, 5'($random(seed))}, 4, 3'd5, 5, opOpImm), st);
            end else begin
                issueInstr(encI(12'($random(seed)) | 12'h800, 3, 3'(f), 4, opOpImm), st);
                issueInstr(encI(12'($random(seed)), 4, 3'(f), 5, opOpImm), st);
            end
        end
        issueInstr(encI(12'd5, 1, 3'd0, 0, opOpImm), st);  // Write to x0
        // Nops until the x0 write has passed writeback
        issueInstr(encI(12'd0, 0, 3'd0, 0, opOpImm), st);
        issueInstr(encI(12'd0, 0, 3'd0, 0, opOpImm), st);
        issueInstr(encR(1'b0, 0, 0, 3'd0, 6), st);
    endtask

    task automatic testMemory();
        int st;
        issueInstr(encS(12'd100, 3, 0), st);
        issueInstr(encI(12'd100, 0, 3'b010, 7, opLoad), st);
        issueInstr(encI(12'd64, 0, 3'd0, 8, opOpImm), st);
        issueInstr(encS(12'hFF8, 5, 8), st);  // Negative offset
        issueInstr(encI(12'hFF8, 8, 3'b010, 9, opLoad), st);
    endtask

    task automatic testDeps();
        int st;
        issueInstr(encI(12'd5, 0, 3'd0, 10, opOpImm), st);
        issueInstr(encI(12'd3, 10, 3'd0, 10, opOpImm), st);
        checkStalls("aluUseStall", 1, st);
        issueInstr(encI(12'd7, 0, 3'd0, 11, opOpImm), st);
        issueInstr(encI(12'd1, 0, 3'd0, 12, opOpImm), st);
        issueInstr(encR(1'b0, 11, 11, 3'd0, 13), st);  // Two apart
        checkStalls("bypassStall", 0, st);
        issueInstr(encI(12'd100, 0, 3'b010, 14, opLoad), st);
        issueInstr(encR(1'b1, 14, 13, 3'd0, 15), st);
        checkStalls("loadUseStall", 1, st);
    endtask

    task automatic testBranches();
        logic [2:0] f3s [6] = '{0, 1, 4, 5, 6, 7};
        logic [11:0] av [3] = '{12'd5, 12'hFFD, 12'd5};
        logic [11:0] bv [3] = '{12'd5, 12'd5, 12'hFFD};
        logic [12:0] off;
        logic [31:0] bpc, tgt;
        logic tk;
        int st;
        for (int f = 0; f < 6; f++) begin
            for (int p = 0; p < 3; p++) begin
                issueInstr(encI(av[p], 0, 3'd0, 20, opOpImm), st);
                issueInstr(encI(bv[p], 0, 3'd0, 21, opOpImm), st);
                off = 13'($random(seed)) & 13'h1FFC;
                bpc = pcNow;
                tk = refCond(f3s[f], refRegs[20], refRegs[21]);
                tgt = bpc + {{19{off[12]}}, off};
                issueInstr(encB(off, 21, 20, f3s[f]), st);
                @(negedge clk);
                checkBranch("branch", tk, tgt, branchTaken, branchTarget);
                instr = encI(12'd1, 22, 3'd0, 22, opOpImm);  // Shadow slot
                instPc = pcNow;
                if (!tk) begin
                    issuedCount++;
                    modelExec(instr, cycleCount + 1);
                end
                pcNow = tk ? tgt : pcNow + 4;
            end
        end
    endtask

    task automatic testUnknown();
        int st;
        issueInstr(32'hFFFF_FFFF, st);
        @(negedge clk);
        instValid = 1'b0;
        if (memRdEn || memWrEn || branchTaken) begin
            errCount++;
            $display("Unknown opcode caused a memory access or branch");
        end
    endtask

    initial begin
        instValid = 1'b0;
        instr = '0;
        instPc = '0;
        memRdData <= '0;
        for (int i = 0; i < 256; i++) begin
            refMem[i] = $random(seed);
            dataMem[i] <= refMem[i];
        end
        for (int i = 0; i < regDepth; i++) refRegs[i] = '0;
        @(posedge rstN);
        testReset();
        testRType();
        testIType();
        testMemory();
        testDeps();
        testBranches();
        testUnknown();
        @(negedge clk);
        instValid = 1'b0;
        while (expAddr.size() > 0 || stAddr.size() > 0) @(negedge clk);
        repeat (3) @(negedge clk);
        $display("Errors: %0d, writes checked: %0d", errCount, writesSeen);
        if (errCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
hw/rv32iPkg.sv
hw/idExIf.sv
hw/idControl.sv
hw/regFile.sv
hw/hazardUnit.sv
hw/aluUnit.sv
hw/coreTop.sv
tests/tbClock.sv
tests/tbCore.sv

// ==== Makefile ====
# Verilator simulation of the RV32I pipeline core

VERILATOR ?= verilator
TOP       ?= tbCore
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= Test OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
